/* rtl/chessCfg.svh */
`ifndef CHESS_CFG_SVH
`define CHESS_CFG_SVH

////////////////////////////////////////
// Board layout in pixels
////////////////////////////////////////

`define CELL_SIZE     55
`define BOARD_X0      102
`define BOARD_Y0      20
`define PIECE_MARGIN  8

////////////////////////////////////////
// Widths and counts
////////////////////////////////////////

`define COORD_W       10
`define COLOR_W       4
`define NUM_PIECES    32
// Captures that can be taken back
`define UNDO_DEPTH    2

`endif

/* rtl/chessPkg.sv */
package chessPkg;

`include "chessCfg.svh"

    // Column counts left to right, row top to bottom
    typedef struct packed {
        logic [2:0] col;
        logic [2:0] row;
    } squareT;

    // Upper bit set for black pieces
    typedef logic [4:0] pieceIdxT;

    typedef enum logic [2:0] {
        PAWN   = 3'd0,
        ROOK   = 3'd1,
        BISHOP = 3'd2,
        KNIGHT = 3'd3,
        QUEEN  = 3'd4,
        KING   = 3'd5
    } pieceKindT;

    typedef logic [`COLOR_W-1:0] colorT;

    localparam colorT LIGHT_R = 4'd14;
    localparam colorT LIGHT_G = 4'd13;
    localparam colorT LIGHT_B = 4'd11;
    localparam colorT DARK_R  = 4'd8;
    localparam colorT DARK_G  = 4'd5;
    localparam colorT DARK_B  = 4'd3;

    function automatic pieceKindT kindOf(input pieceIdxT idx);
        logic [3:0] n;
        n = idx[3:0];
        if (n < 4'd8) begin
            return PAWN;
        end else if (n < 4'd10) begin
            return ROOK;
        end else if (n < 4'd12) begin
            return BISHOP;
        end else if (n < 4'd14) begin
            return KNIGHT;
        end else if (n == 4'd14) begin
            return QUEEN;
        end
        return KING;
    endfunction

    function automatic squareT homeSquare(input pieceIdxT idx);
        logic [3:0] n;
        logic [2:0] backCol;
        squareT sq;
        n = idx[3:0];
        case (n)
            4'd8:    backCol = 3'd0;
            4'd9:    backCol = 3'd7;
            4'd10:   backCol = 3'd2;
            4'd11:   backCol = 3'd5;
            4'd12:   backCol = 3'd1;
            4'd13:   backCol = 3'd6;
            4'd14:   backCol = 3'd3;
            default: backCol = 3'd4;
        endcase
        if (n < 4'd8) begin
            sq.col = n[2:0];
            sq.row = idx[4] ? 3'd1 : 3'd6;
        end else begin
            sq.col = backCol;
            sq.row = idx[4] ? 3'd0 : 3'd7;
        end
        return sq;
    endfunction

    // Grey level per kind, white pieces bright and black ones dim
    function automatic colorT pieceShade(input pieceKindT kind, input logic isBlack);
        if (isBlack) begin
            return colorT'(4'd2 + 4'(kind));
        end
        return colorT'(4'd15 - 4'(kind));
    endfunction

endpackage

/* rtl/boardGeometry.sv */
`timescale 1ns/1ns
`include "chessCfg.svh"

module boardGeometry
    import chessPkg::*;
(
    input  logic                Clk,
    input  logic                arstN,
    input  logic [`COORD_W-1:0] drawX,
    input  logic [`COORD_W-1:0] drawY,
    output logic                onBoard,
    output logic                inPiece,
    output logic                lightSquare,
    output squareT              square
);

    localparam logic [`COORD_W-1:0] X0       = `BOARD_X0;
    localparam logic [`COORD_W-1:0] Y0       = `BOARD_Y0;
    localparam logic [`COORD_W-1:0] CELL     = `CELL_SIZE;
    localparam logic [`COORD_W-1:0] SPAN     = 8 * `CELL_SIZE;
    localparam logic [`COORD_W-1:0] PIECE_LO = `PIECE_MARGIN;
    localparam logic [`COORD_W-1:0] PIECE_HI = `CELL_SIZE - 1 - `PIECE_MARGIN;

    logic [`COORD_W-1:0] relX;
    logic [`COORD_W-1:0] relY;
    logic [`COORD_W-1:0] colFull;
    logic [`COORD_W-1:0] rowFull;
    logic [`COORD_W-1:0] offX;
    logic [`COORD_W-1:0] offY;
    logic                hitX;
    logic                hitY;

    // Wraps to a large value left of and above the board
    assign relX = drawX - X0;
    assign relY = drawY - Y0;

    assign hitX = (drawX >= X0) && (relX < SPAN);
    assign hitY = (drawY >= Y0) && (relY < SPAN);

    assign colFull = relX / CELL;
    assign rowFull = relY / CELL;
    assign offX    = relX % CELL;
    assign offY    = relY % CELL;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            onBoard     <= 1'b0;
            inPiece     <= 1'b0;
            lightSquare <= 1'b0;
        end else begin
            onBoard     <= hitX && hitY;
            inPiece     <= (offX >= PIECE_LO) && (offX <= PIECE_HI)
                        && (offY >= PIECE_LO) && (offY <= PIECE_HI);
            // Light when column plus row is even
            lightSquare <= ~(colFull[0] ^ rowFull[0]);
        end
    end

    always_ff @(posedge Clk) begin
        square.col <= colFull[2:0];
        square.row <= rowFull[2:0];
    end

    // The cell must enclose the coordinate it came from
    assert property (@(posedge Clk) disable iff (!arstN)
        onBoard |-> ($past(drawX) >= X0 + square.col * CELL)
                 && ($past(drawX) <  X0 + (square.col + 1'b1) * CELL)
                 && ($past(drawY) >= Y0 + square.row * CELL)
                 && ($past(drawY) <  Y0 + (square.row + 1'b1) * CELL));

endmodule

/* rtl/pieceTable.sv */
`timescale 1ns/1ns
`include "chessCfg.svh"

module pieceTable
    import chessPkg::*;
(
    input  logic                   Clk,
    input  logic                   arstN,
    input  logic                   wrEn,
    input  logic                   capture,
    input  logic                   undo,
    input  pieceIdxT               wrIdx,
    input  pieceIdxT               capIdx,
    input  squareT                 wrSquare,
    output squareT                 pieceSquare [`NUM_PIECES],
    output logic [`NUM_PIECES-1:0] pieceLive
);

    localparam int               CNT_W = $clog2(`UNDO_DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL  = `UNDO_DEPTH;

    // Entry 0 is the newest capture
    pieceIdxT         history [`UNDO_DEPTH];
    logic [CNT_W-1:0] histCount;
    logic             doUndo;

    assign doUndo = undo && (histCount != '0);

    ////////////////////////////////////////
    // Positions and live flags
    ////////////////////////////////////////

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `NUM_PIECES; i++) begin
                pieceSquare[i] <= homeSquare(pieceIdxT'(i));
            end
            pieceLive <= '1;
        end else begin
            if (wrEn) begin
                pieceSquare[wrIdx] <= wrSquare;
            end
            if (capture) begin
                pieceLive[capIdx] <= 1'b0;
            end else if (doUndo) begin
                pieceLive[history[0]] <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Capture history
    ////////////////////////////////////////

    // Saturates when full, the oldest entry falls off the end
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            histCount <= '0;
        end else if (capture) begin
            if (histCount != FULL) begin
                histCount <= histCount + 1'b1;
            end
        end else if (doUndo) begin
            histCount <= histCount - 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (capture) begin
            history[0] <= capIdx;
            for (int i = 1; i < `UNDO_DEPTH; i++) begin
                history[i] <= history[i-1];
            end
        end else if (doUndo) begin
            for (int i = 0; i < `UNDO_DEPTH - 1; i++) begin
                history[i] <= history[i+1];
            end
        end
    end

    // Host issues one command per cycle
    assert property (@(posedge Clk) disable iff (!arstN)
        $onehot0({wrEn, capture, undo}));

endmodule

/* rtl/pieceLocator.sv */
`timescale 1ns/1ns
`include "chessCfg.svh"

module pieceLocator
    import chessPkg::*;
(
    input  logic                   Clk,
    input  logic                   arstN,
    input  logic                   onBoardIn,
    input  logic                   inPieceIn,
    input  logic                   lightIn,
    input  squareT                 square,
    input  squareT                 pieceSquare [`NUM_PIECES],
    input  logic [`NUM_PIECES-1:0] pieceLive,
    output logic                   hit,
    output pieceKindT              kind,
    output logic                   isBlack,
    output logic                   onBoard,
    output logic                   inPiece,
    output logic                   lightSquare
);

    logic [`NUM_PIECES-1:0] match;
    pieceIdxT               firstIdx;

    always_comb begin
        for (int i = 0; i < `NUM_PIECES; i++) begin
            match[i] = pieceLive[i] && (pieceSquare[i] == square);
        end
    end

    // Lowest index wins when pieces share a square
    always_comb begin
        firstIdx = '0;
        for (int i = `NUM_PIECES - 1; i >= 0; i--) begin
            if (match[i]) begin
                firstIdx = pieceIdxT'(i);
            end
        end
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            hit         <= 1'b0;
            onBoard     <= 1'b0;
            inPiece     <= 1'b0;
            lightSquare <= 1'b0;
        end else begin
            // Square is only meaningful on the board
            hit         <= onBoardIn && (|match);
            onBoard     <= onBoardIn;
            inPiece     <= inPieceIn;
            lightSquare <= lightIn;
        end
    end

    always_ff @(posedge Clk) begin
        kind    <= kindOf(firstIdx);
        isBlack <= firstIdx[4];
    end

endmodule

/* rtl/pixelComposer.sv */
`timescale 1ns/1ns
`include "chessCfg.svh"

module pixelComposer
    import chessPkg::*;
(
    input  logic      Clk,
    input  logic      arstN,
    input  logic      blankN,
    input  logic      onBoard,
    input  logic      inPiece,
    input  logic      lightSquare,
    input  logic      hit,
    input  logic      isBlack,
    input  pieceKindT kind,
    output colorT     red,
    output colorT     green,
    output colorT     blue
);

    colorT shade;
    colorT redNext;
    colorT greenNext;
    colorT blueNext;

    assign shade = pieceShade(kind, isBlack);

    always_comb begin
        if (!blankN) begin
            redNext   = '1;
            greenNext = '1;
            blueNext  = '1;
        end else if (!onBoard) begin
            redNext   = '0;
            greenNext = '0;
            blueNext  = '0;
        end else if (hit && inPiece) begin
            // Flat grey piece body
            redNext   = shade;
            greenNext = shade;
            blueNext  = shade;
        end else if (lightSquare) begin
            redNext   = LIGHT_R;
            greenNext = LIGHT_G;
            blueNext  = LIGHT_B;
        end else begin
            redNext   = DARK_R;
            greenNext = DARK_G;
            blueNext  = DARK_B;
        end
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else begin
            red   <= redNext;
            green <= greenNext;
            blue  <= blueNext;
        end
    end

    // Locator must never report a piece off the board
    assert property (@(posedge Clk) disable iff (!arstN)
        hit |-> onBoard);

endmodule

/* rtl/chessRenderer.sv */
`timescale 1ns/1ns
`include "chessCfg.svh"

module chessRenderer
    import chessPkg::*;
(
    input  logic                Clk,
    input  logic                arstN,
    input  logic                blankN,
    input  logic [`COORD_W-1:0] drawX,
    input  logic [`COORD_W-1:0] drawY,
    input  logic                wrEn,
    input  logic                capture,
    input  logic                undo,
    input  pieceIdxT            wrIdx,
    input  pieceIdxT            capIdx,
    input  squareT              wrSquare,
    output colorT               red,
    output colorT               green,
    output colorT               blue
);

    // Stage 1, geometry
    logic      onBoard1;
    logic      inPiece1;
    logic      light1;
    squareT    square1;

    // Stage 2, piece lookup
    logic      hit2;
    pieceKindT kind2;
    logic      isBlack2;
    logic      onBoard2;
    logic      inPiece2;
    logic      light2;

    squareT                 pieceSquare [`NUM_PIECES];
    logic [`NUM_PIECES-1:0] pieceLive;

    // Blanking rides alongside its pixel
    logic blankD1;
    logic blankD2;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            blankD1 <= 1'b1;
            blankD2 <= 1'b1;
        end else begin
            blankD1 <= blankN;
            blankD2 <= blankD1;
        end
    end

    boardGeometry uGeometry (
        .Clk(Clk),
        .arstN(arstN),
        .drawX(drawX),
        .drawY(drawY),
        .onBoard(onBoard1),
        .inPiece(inPiece1),
        .lightSquare(light1),
        .square(square1)
    );

    pieceTable uTable (
        .Clk(Clk),
        .arstN(arstN),
        .wrEn(wrEn),
        .capture(capture),
        .undo(undo),
        .wrIdx(wrIdx),
        .capIdx(capIdx),
        .wrSquare(wrSquare),
        .pieceSquare(pieceSquare),
        .pieceLive(pieceLive)
    );

    pieceLocator uLocator (
        .Clk(Clk),
        .arstN(arstN),
        .onBoardIn(onBoard1),
        .inPieceIn(inPiece1),
        .lightIn(light1),
        .square(square1),
        .pieceSquare(pieceSquare),
        .pieceLive(pieceLive),
        .hit(hit2),
        .kind(kind2),
        .isBlack(isBlack2),
        .onBoard(onBoard2),
        .inPiece(inPiece2),
        .lightSquare(light2)
    );

    pixelComposer uComposer (
        .Clk(Clk),
        .arstN(arstN),
        .blankN(blankD2),
        .onBoard(onBoard2),
        .inPiece(inPiece2),
        .lightSquare(light2),
        .hit(hit2),
        .isBlack(isBlack2),
        .kind(kind2),
        .red(red),
        .green(green),
        .blue(blue)
    );

endmodule

/* bench/chessRendererTb.sv */
`timescale 1ns/1ns
`include "chessCfg.svh"

module chessRendererTb;

    localparam int LATENCY     = 3;
    localparam int RESET_LIMIT = 10;
    localparam int LINE_LIMIT  = 1000;
    localparam int DRAIN_LIMIT = 10;

    logic                Clk;
    logic                arstN;
    logic                blankN;
    logic [`COORD_W-1:0] drawX;
    logic [`COORD_W-1:0] drawY;
    logic                wrEn;
    logic                capture;
    logic                undo;
    logic [4:0]          wrIdx;
    logic [4:0]          capIdx;
    logic [5:0]          wrSquare;
    logic [`COLOR_W-1:0] red;
    logic [`COLOR_W-1:0] green;
    logic [`COLOR_W-1:0] blue;

    int cycleNum;
    int checks;
    int mismatches;
    int otherFails;

    // Pixels in flight, oldest first
    int dueCycle [$];
    int dueX [$];
    int dueY [$];
    int dueR [$];
    int dueG [$];
    int dueB [$];

    chessRenderer uut (
        .Clk(Clk),
        .arstN(arstN),
        .blankN(blankN),
        .drawX(drawX),
        .drawY(drawY),
        .wrEn(wrEn),
        .capture(capture),
        .undo(undo),
        .wrIdx(wrIdx),
        .capIdx(capIdx),
        .wrSquare(wrSquare),
        .red(red),
        .green(green),
        .blue(blue)
    );

    always #2 Clk = ~Clk;

    initial begin : resetGen
        arstN = 1'b0;
        repeat (3) @(posedge Clk);
        #1;
        arstN = 1'b1;
    end

    ////////////////////////////////////////
    // Stimulus and checking helpers
    ////////////////////////////////////////

    task automatic driveIdle();
        blankN   = 1'b1;
        drawX    = '0;
        drawY    = '0;
        wrEn     = 1'b0;
        capture  = 1'b0;
        undo     = 1'b0;
        wrIdx    = '0;
        capIdx   = '0;
        wrSquare = '0;
    endtask

    task automatic checkZero();
        checks++;
        assert (red == 0 && green == 0 && blue == 0) else begin
            mismatches++;
            $display("[ERROR] %0t ns: outputs expected 0/0/0 before first pixel, got %0d/%0d/%0d",
                     $time, red, green, blue);
        end
    endtask

    task automatic checkDue();
        int x;
        int y;
        int er;
        int eg;
        int eb;
        while (dueCycle.size() > 0 && dueCycle[0] == cycleNum) begin
            void'(dueCycle.pop_front());
            x  = dueX.pop_front();
            y  = dueY.pop_front();
            er = dueR.pop_front();
            eg = dueG.pop_front();
            eb = dueB.pop_front();
            checks++;
            assert (red == er && green == eg && blue == eb) else begin
                mismatches++;
                $display("[ERROR] %0t ns: pixel (%0d,%0d) expected %0d/%0d/%0d got %0d/%0d/%0d",
                         $time, x, y, er, eg, eb, red, green, blue);
            end
        end
    endtask

    task automatic stepCycle();
        @(posedge Clk);
        #1;
        cycleNum++;
        driveIdle();
        checkDue();
    endtask

    task automatic applyCommand(input string line);
        int a;
        int b;
        int c;
        int r;
        int g;
        int bl;
        int n;
        byte op;
        op = line.getc(0);
        n  = 0;
        if (op == "W") begin
            n        = $sscanf(line, "W %d %d %d", a, b, c);
            wrEn     = 1'b1;
            wrIdx    = a[4:0];
            wrSquare = {b[2:0], c[2:0]};
        end else if (op == "C") begin
            n       = $sscanf(line, "C %d", a);
            capture = 1'b1;
            capIdx  = a[4:0];
        end else if (op == "U") begin
            undo = 1'b1;
        end else if (op == "P") begin
            n      = $sscanf(line, "P %d %d %d %d %d %d", a, b, c, r, g, bl);
            drawX  = a[`COORD_W-1:0];
            drawY  = b[`COORD_W-1:0];
            blankN = c[0];
            // Colour appears LATENCY edges after the inputs are sampled
            dueCycle.push_back(cycleNum + LATENCY);
            dueX.push_back(a);
            dueY.push_back(b);
            dueR.push_back(r);
            dueG.push_back(g);
            dueB.push_back(bl);
        end
        if ((op == "W" && n != 3) || (op == "C" && n != 1) || (op == "P" && n != 6)
            || (op != "W" && op != "C" && op != "U" && op != "P")) begin
            otherFails++;
            $display("Pattern line could not be understood: %s", line);
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin : mainSeq
        int    fd;
        int    status;
        int    lineCount;
        int    waitCount;
        bit    timedOut;
        string line;
        Clk        = 1'b0;
        cycleNum   = 0;
        checks     = 0;
        mismatches = 0;
        otherFails = 0;
        timedOut   = 1'b0;
        driveIdle();
        // White would leak out if reset did not clear the pipeline
        blankN = 1'b0;

        waitCount = 0;
        do begin
            @(negedge Clk);
            waitCount++;
            checkZero();
        end while (!arstN && waitCount < RESET_LIMIT);
        if (!arstN) begin
            timedOut = 1'b1;
            otherFails++;
            $display("Reset was not released within %0d cycles", RESET_LIMIT);
        end

        if (!timedOut) begin
            @(posedge Clk);
            #1;
            // Only the first stage has seen a pixel so far
            checkZero();
            driveIdle();
            fd = $fopen("bench/chessPatterns.txt", "r");
            if (fd == 0) begin
                otherFails++;
                $display("Could not open the pattern file bench/chessPatterns.txt");
            end else begin
                lineCount = 0;
                status    = $fgets(line, fd);
                while (status != 0 && lineCount < LINE_LIMIT) begin
                    lineCount++;
                    if (line.len() > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
                        applyCommand(line);
                        stepCycle();
                    end
                    status = $fgets(line, fd);
                end
                if (status != 0) begin
                    otherFails++;
                    $display("Pattern file did not end within %0d lines", LINE_LIMIT);
                end
                $fclose(fd);
            end

            waitCount = 0;
            while (dueCycle.size() > 0 && waitCount < DRAIN_LIMIT) begin
                stepCycle();
                waitCount++;
            end
            if (dueCycle.size() > 0) begin
                otherFails++;
                $display("%0d pixels never reached the outputs", dueCycle.size());
            end
        end

        $display("Checks: %0d, mismatches: %0d, other failures: %0d",
                 checks, mismatches, otherFails);
        if (mismatches == 0 && otherFails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* bench/chessPatterns.txt */
# One command per line, decimal values
# W piece col row | C piece | U | P x y blankN red green blue
# Home squares after reset
P 129 47 1 3 3 3
P 184 47 1 5 5 5
P 239 47 1 4 4 4
P 294 47 1 6 6 6
P 349 47 1 7 7 7
P 514 47 1 3 3 3
P 129 102 1 2 2 2
P 459 102 1 2 2 2
P 129 432 1 14 14 14
P 184 432 1 12 12 12
P 239 432 1 13 13 13
P 294 432 1 11 11 11
P 349 432 1 10 10 10
P 514 377 1 15 15 15
# Empty middle squares
P 129 157 1 14 13 11
P 184 157 1 8 5 3
P 294 267 1 8 5 3
P 349 267 1 14 13 11
# Board edges, piece margin and blanking
P 101 157 1 0 0 0
P 300 19 1 0 0 0
P 300 460 1 0 0 0
P 541 459 1 14 13 11
P 109 432 1 8 5 3
P 110 432 1 14 14 14
P 148 432 1 14 14 14
P 149 432 1 8 5 3
P 349 47 0 15 15 15
P 0 0 0 15 15 15
# Move white pawn 4 to an empty square
W 4 4 4
P 349 267 1 15 15 15
P 349 377 1 14 13 11
# Capture black queen then white knight, undo both, one spare undo
C 30
C 12
P 294 47 1 8 5 3
P 184 432 1 14 13 11
U
P 184 432 1 12 12 12
P 294 47 1 8 5 3
U
P 294 47 1 6 6 6
U
P 294 47 1 6 6 6
P 184 432 1 12 12 12
# Shared squares draw the lower index piece
W 16 4 4
P 349 267 1 15 15 15
P 129 102 1 8 5 3
W 0 7 1
P 514 102 1 15 15 15
P 129 377 1 14 13 11
# Back to back run across cell borders
P 156 157 1 14 13 11
P 157 157 1 8 5 3
P 129 212 1 8 5 3
P 184 212 1 14 13 11
P 239 212 1 8 5 3

/* compile.f */
+incdir+rtl
rtl/chessPkg.sv
rtl/boardGeometry.sv
rtl/pieceTable.sv
rtl/pieceLocator.sv
rtl/pixelComposer.sv
rtl/chessRenderer.sv
bench/chessRendererTb.sv
